//--- sources.f
hw/dqmPkg.sv
hw/bitFifo.sv
hw/pingPongWriter.sv
hw/frameSerializer.sv
hw/dqmFramerTop.sv
bench/dqmFramerTb.sv

//--- Makefile
TOP = dqmFramerTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/dqmTrace.txt
# dqm(hex) payloadSize(length-1) clksPerBit(period-1) frames gap(cycles) overrun(0/1) header(hex)
# With overrun 1 the input runs fast until an overrun, then the given frames follow the flush
1234 15 0 3 4 0 EB90000A1234
BEEF 63 2 4 5 0 EB90000ABEEF
0000 0 1 3 109 0 EB90000A0000
FFFF 99 0 2 1 0 EB90000AFFFF
5A3C 31 4 2 13 0 EB90000A5A3C
A5C3 7 3 1 0 1 EB90000AA5C3

//--- bench/dqmFramerTb.sv
`timescale 1ns/100ps

module dqmFramerTb import dqmPkg::*; ();

    typedef struct packed {
        logic [15:0] dqm;
        logic [13:0] payloadSize;
        logic [15:0] clksPerBit;
        logic [15:0] frames;
        logic [15:0] gap;
        logic        expectOverrun;
        logic [47:0] header;
    } testLine_t;

    logic        clk;
    logic        reset;
    frameCfg_t   cfg;
    payloadIn_t  payload;
    serialOut_t  out;
    logic        startOfFrame;
    logic        overrun;

    testLine_t   tests[$];
    testLine_t   cur;
    logic        sentBits[$];
    logic [31:0] rngState;
    logic [47:0] headerAcc;
    int          cycleCount;
    int          cycleLimit;
    int          lastStrobe;
    int          bitIdx;
    int          framesDone;
    int          sofCount;
    int          acceptedCount;
    int          overrunCount;
    bit          testActive;
    bit          quietPhase;
    bit          allowOverrun;

    dqmFramerTop #(.VERSION(4'hA), .FIFO_DEPTH(256)) DUT (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .payload     (payload),
        .out         (out),
        .startOfFrame(startOfFrame),
        .overrun     (overrun)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            abortRun($sformatf("Timeout: run still busy after %0d clock cycles", cycleLimit));
        end
    end

    // Frames are split by count, header first and then the payload
    task automatic collectBit(input logic value);
        int payloadLen;
        int idx;
        payloadLen = int'(cur.payloadSize) + 1;
        if (bitIdx > 0) begin
            checkValue("out.bitEn spacing", cycleCount - lastStrobe, int'(cur.clksPerBit) + 1);
        end
        lastStrobe = cycleCount;
        if (bitIdx < headerBits) begin
            headerAcc = {headerAcc[46:0], value};
            if (bitIdx == headerBits - 1) begin
                checkValue("frame header", headerAcc, cur.header);
            end
        end else begin
            idx = bitIdx - headerBits;
            if (idx >= sentBits.size()) begin
                abortRun("An output payload bit appeared with no matching input bit");
            end
            checkValue($sformatf("out.bitVal payload bit %0d", idx), value, sentBits[idx]);
        end
        bitIdx++;
        if (bitIdx == headerBits + payloadLen) begin
            repeat (payloadLen) sentBits.delete(0);
            bitIdx = 0;
            framesDone++;
        end
    endtask

    always @(negedge clk) begin
        if (testActive && !reset) begin
            if (quietPhase) begin
                checkValue("out.bitEn", out.bitEn, 0);
                checkValue("startOfFrame", startOfFrame, 0);
                checkValue("overrun", overrun, 0);
            end
            if (out.bitEn) begin
                collectBit(out.bitVal);
            end
            if (startOfFrame) begin
                checkValue("payload.bitEn at startOfFrame", payload.bitEn, 1);
                checkValue("input bits at startOfFrame modulo frame length",
                           acceptedCount % (int'(cur.payloadSize) + 1), 0);
                sofCount++;
            end
            if (overrun) begin
                checkValue("overrun", overrun, allowOverrun);
                // Both buffers get flushed, so everything in flight is dropped
                overrunCount++;
                sentBits.delete();
                bitIdx = 0;
                acceptedCount = 0;
                sofCount = 0;
                framesDone = 0;
            end
        end
    end

    task automatic driveBits(input int count, input int gap, input bit stopOnOverrun);
        int   sent;
        bit   stopped;
        logic value;
        sent = 0;
        stopped = 1'b0;
        while (sent < count && !stopped) begin
            @(posedge clk);
            if (stopOnOverrun && overrunCount != 0) begin
                payload.bitEn <= 1'b0;
                stopped = 1'b1;
            end else begin
                rngState = lcgNext(rngState);
                value = rngState[31];
                payload.bitEn <= 1'b1;
                payload.bitVal <= value;
                sentBits.push_back(value);
                acceptedCount++;
                sent++;
                repeat (gap) begin
                    @(posedge clk);
                    payload.bitEn <= 1'b0;
                end
            end
        end
        @(posedge clk);
        payload.bitEn <= 1'b0;
    endtask

    task automatic runTest(input testLine_t t);
        int frameLen;
        frameLen = int'(t.payloadSize) + 1;
        testActive = 1'b0;
        @(posedge clk);
        reset <= 1'b1;
        cfg <= '{dqm: t.dqm, payloadSize: t.payloadSize, clksPerBit: t.clksPerBit};
        payload <= '0;
        cur = t;
        sentBits.delete();
        bitIdx = 0;
        framesDone = 0;
        sofCount = 0;
        acceptedCount = 0;
        overrunCount = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        testActive = 1'b1;
        quietPhase = 1'b1;
        repeat (16) @(posedge clk);
        quietPhase = 1'b0;
        if (t.expectOverrun) begin
            allowOverrun = 1'b1;
            driveBits(4 * frameLen, int'(t.gap), 1'b1);
            if (overrunCount == 0) begin
                abortRun("Fast input never caused the expected overrun");
            end
            // Let the flush drain both buffers before input resumes
            repeat (frameLen + 10) @(posedge clk);
            allowOverrun = 1'b0;
        end
        driveBits(int'(t.frames) * frameLen, int'(t.gap), 1'b0);
        wait (framesDone == int'(t.frames));
        repeat (2 * (int'(t.clksPerBit) + 1) + 4) @(posedge clk);
        checkValue("output bits past the last frame", bitIdx, 0);
        checkValue("startOfFrame count", sofCount, t.frames);
        testActive = 1'b0;
    endtask

    initial begin : mainFlow
        int          fd;
        int          n;
        int          sizeV;
        int          rateV;
        int          framesV;
        int          gapV;
        int          ovrV;
        logic [15:0] dqmV;
        logic [47:0] hdrV;
        string       line;
        testLine_t   t;

        clk = 1'b0;
        reset = 1'b1;
        cfg = '0;
        payload = '0;
        rngState = 32'h5b6f_a781;
        headerAcc = '0;
        cycleCount = 0;
        cycleLimit = 0;
        lastStrobe = 0;
        bitIdx = 0;
        framesDone = 0;
        sofCount = 0;
        acceptedCount = 0;
        overrunCount = 0;
        testActive = 1'b0;
        quietPhase = 1'b0;
        allowOverrun = 1'b0;

        fd = $fopen("bench/dqmTrace.txt", "r");
        if (fd == 0) begin
            abortRun("Cannot open the trace file bench/dqmTrace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %d %d %d %d %d %h",
                            dqmV, sizeV, rateV, framesV, gapV, ovrV, hdrV);
                if (n == 7) begin
                    t.dqm = dqmV;
                    t.payloadSize = sizeV[13:0];
                    t.clksPerBit = rateV[15:0];
                    t.frames = framesV[15:0];
                    t.gap = gapV[15:0];
                    t.expectOverrun = (ovrV != 0);
                    t.header = hdrV;
                    tests.push_back(t);
                    cycleLimit += framesV * (headerBits + sizeV + 1) * (rateV + 1) * 2;
                end else if (n > 0) begin
                    abortRun("The trace file holds a line that is not seven fields");
                end
            end
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            abortRun("The trace file holds no tests");
        end
        cycleLimit += 1000;

        foreach (tests[i]) begin
            runTest(tests[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- hw/dqmFramerTop.sv
`timescale 1ns/100ps

module dqmFramerTop import dqmPkg::*; #(
    parameter logic [versionWidth-1:0] VERSION = 4'h0,
    parameter int FIFO_DEPTH = 16384
) (
    input  logic       clk,
    input  logic       reset,
    input  frameCfg_t  cfg,
    input  payloadIn_t payload,
    output serialOut_t out,
    output logic       startOfFrame,
    output logic       overrun
);

    logic pingWrEn;
    logic pongWrEn;
    logic pingRdEn;
    logic pongRdEn;
    logic pingBit;
    logic pongBit;
    logic pingEmpty;
    logic pongEmpty;
    logic readPing;
    logic flush;

    pingPongWriter writer (
        .clk        (clk),
        .reset      (reset),
        .payload    (payload),
        .payloadSize(cfg.payloadSize),
        .pingEmpty  (pingEmpty),
        .pongEmpty  (pongEmpty),
        .pingWrEn   (pingWrEn),
        .pongWrEn   (pongWrEn),
        .readPing   (readPing),
        .frameStart (startOfFrame),
        .flush      (flush),
        .overrun    (overrun)
    );

    bitFifo #(.FIFO_DEPTH(FIFO_DEPTH)) pingFifo (
        .clk  (clk),
        .reset(reset),
        .wrEn (pingWrEn),
        .wrBit(payload.bitVal),
        .rdEn (pingRdEn),
        .rdBit(pingBit),
        .empty(pingEmpty),
        .full ()
    );

    bitFifo #(.FIFO_DEPTH(FIFO_DEPTH)) pongFifo (
        .clk  (clk),
        .reset(reset),
        .wrEn (pongWrEn),
        .wrBit(payload.bitVal),
        .rdEn (pongRdEn),
        .rdBit(pongBit),
        .empty(pongEmpty),
        .full ()
    );

    frameSerializer #(.VERSION(VERSION)) serializer (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .frameStart(startOfFrame),
        .flush     (flush),
        .readPing  (readPing),
        .pingBit   (pingBit),
        .pongBit   (pongBit),
        .pingEmpty (pingEmpty),
        .pongEmpty (pongEmpty),
        .pingRdEn  (pingRdEn),
        .pongRdEn  (pongRdEn),
        .out       (out)
    );

endmodule

//--- hw/frameSerializer.sv
`timescale 1ns/100ps

module frameSerializer import dqmPkg::*; #(
    parameter logic [versionWidth-1:0] VERSION = 4'h0
) (
    input  logic       clk,
    input  logic       reset,
    input  frameCfg_t  cfg,
    input  logic       frameStart,
    input  logic       flush,
    input  logic       readPing,
    input  logic       pingBit,
    input  logic       pongBit,
    input  logic       pingEmpty,
    input  logic       pongEmpty,
    output logic       pingRdEn,
    output logic       pongRdEn,
    output serialOut_t out
);

    logic [rateWidth-1:0]  rateCount;
    logic                  bitStrobe;

    frameState_t           state;
    logic                  startPending;
    logic [headerBits-1:0] headerSr;
    logic [sizeWidth-1:0]  bitCount;
    logic [dqmWidth-1:0]   dqmHold;
    logic                  readSel;

    logic                  holdIdle;
    logic                  startNow;
    logic                  readNext;
    logic [dqmWidth-1:0]   headerDqm;

    // Free running bit-rate strobe, one pulse every clksPerBit+1 cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            rateCount <= '0;
        end else if (rateCount == '0) begin
            rateCount <= cfg.clksPerBit;
        end else begin
            rateCount <= rateCount - 1'b1;
        end
    end

    assign bitStrobe = (rateCount == '0);

    // The flush-exit strobe may close a frame, so it is not held off
    assign holdIdle = flush && !frameStart;
    assign startNow = frameStart || startPending;
    assign headerDqm = frameStart ? cfg.dqm : dqmHold;

    // Reads run one strobe ahead: last header bit, then every payload bit but the last
    assign readNext = bitStrobe && !flush &&
                      (((state == frameHeader) && (bitCount == '0)) ||
                       ((state == framePayload) && (bitCount != '0)));

    assign pingRdEn = flush ? !pingEmpty : (readNext && readSel && !pingEmpty);
    assign pongRdEn = flush ? !pongEmpty : (readNext && !readSel && !pongEmpty);

    always_comb begin
        out.bitEn = bitStrobe && !flush && (state != frameIdle);
        if (state == framePayload) begin
            out.bitVal = readSel ? pingBit : pongBit;
        end else begin
            out.bitVal = headerSr[headerBits-1];
        end
    end

    always_ff @(posedge clk) begin
        if (frameStart) begin
            dqmHold <= cfg.dqm;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= frameIdle;
            startPending <= 1'b0;
        end else if (holdIdle) begin
            state <= frameIdle;
            startPending <= 1'b0;
        end else begin
            // Next frame closed while the last payload bit is still going out
            if (state == frameIdle) begin
                startPending <= 1'b0;
            end else if (frameStart) begin
                startPending <= 1'b1;
            end
            case (state)
                frameIdle: begin
                    if (startNow) begin
                        state <= frameWait;
                    end
                end
                frameWait: begin
                    if (bitStrobe) begin
                        state <= frameHeader;
                    end
                end
                frameHeader: begin
                    if (bitStrobe && (bitCount == '0)) begin
                        state <= framePayload;
                    end
                end
                framePayload: begin
                    if (bitStrobe && (bitCount == '0)) begin
                        state <= frameIdle;
                    end
                end
                default: state <= frameIdle;
            endcase
        end
    end

    // Header shift and bit counting
    always_ff @(posedge clk) begin
        case (state)
            frameIdle: begin
                headerSr <= {dqmSyncWord, {padBits{1'b0}}, VERSION, headerDqm};
                bitCount <= sizeWidth'(headerBits - 2);
            end
            frameWait: begin
                if (bitStrobe) begin
                    headerSr <= {headerSr[headerBits-2:0], 1'b0};
                    readSel <= readPing;
                end
            end
            frameHeader: begin
                if (bitStrobe) begin
                    if (bitCount == '0) begin
                        bitCount <= cfg.payloadSize;
                    end else begin
                        bitCount <= bitCount - 1'b1;
                        headerSr <= {headerSr[headerBits-2:0], 1'b0};
                    end
                end
            end
            framePayload: begin
                if (bitStrobe) begin
                    bitCount <= bitCount - 1'b1;
                end
            end
            default: bitCount <= bitCount;
        endcase
    end

    // Every payload read must find a bit waiting in the selected buffer
    payloadReady: assert property (@(posedge clk) disable iff (reset)
        readNext |-> (readSel ? !pingEmpty : !pongEmpty))
        else $error("payload read from an empty buffer");

    // The writer must overrun rather than close a frame over an undrained buffer
    startOnlyWhenFree: assert property (@(posedge clk) disable iff (reset)
        frameStart |-> (state inside {frameIdle, framePayload}))
        else $error("frame closed while header still pending");

endmodule

//--- hw/pingPongWriter.sv
`timescale 1ns/100ps

module pingPongWriter import dqmPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  payloadIn_t           payload,
    input  logic [sizeWidth-1:0] payloadSize,
    input  logic                 pingEmpty,
    input  logic                 pongEmpty,
    output logic                 pingWrEn,
    output logic                 pongWrEn,
    output logic                 readPing,
    output logic                 frameStart,
    output logic                 flush,
    output logic                 overrun
);

    writeState_t          state;
    logic [sizeWidth-1:0] bitsLeft;
    logic                 writePing;

    logic                 accept;
    logic                 curPing;
    logic [sizeWidth-1:0] curLeft;
    logic                 closing;
    logic                 nextEmpty;

    // In flush the strobe that finds both buffers empty starts a fresh frame in ping
    always_comb begin
        if (state == writeFlush) begin
            accept = payload.bitEn && pingEmpty && pongEmpty;
            curPing = 1'b1;
            curLeft = payloadSize;
        end else begin
            accept = payload.bitEn;
            curPing = writePing;
            curLeft = bitsLeft;
        end
        closing = accept && (curLeft == '0);
        // Buffer written after the swap must already be drained
        nextEmpty = curPing ? pongEmpty : pingEmpty;
    end

    assign pingWrEn = accept && curPing;
    assign pongWrEn = accept && !curPing;
    assign frameStart = closing && nextEmpty;
    assign overrun = closing && !nextEmpty;
    assign flush = (state == writeFlush);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= writeFlush;
            bitsLeft <= '0;
            writePing <= 1'b1;
            readPing <= 1'b1;
        end else if (overrun) begin
            state <= writeFlush;
        end else if (accept) begin
            state <= writeFill;
            if (closing) begin
                bitsLeft <= payloadSize;
                writePing <= !curPing;
                readPing <= curPing;
            end else begin
                bitsLeft <= curLeft - 1'b1;
                writePing <= curPing;
            end
        end
    end

    // A new frame always begins in an empty buffer
    freshBufferEmpty: assert property (@(posedge clk) disable iff (reset)
        frameStart |=> (writePing ? pingEmpty : pongEmpty))
        else $error("frame started in a buffer that still holds data");

endmodule

//--- hw/bitFifo.sv
`timescale 1ns/100ps

module bitFifo #(
    parameter int FIFO_DEPTH = 16384
) (
    input  logic clk,
    input  logic reset,
    input  logic wrEn,
    input  logic wrBit,
    input  logic rdEn,
    output logic rdBit,
    output logic empty,
    output logic full
);

    localparam int ptrWidth = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cntWidth = $clog2(FIFO_DEPTH + 1);

    logic                mem [FIFO_DEPTH];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                doWrite;
    logic                doRead;

    assign doWrite = wrEn && !full;
    assign doRead = rdEn && !empty;
    assign empty = (count == '0);
    assign full = (count == cntWidth'(FIFO_DEPTH));

    // Registered read, data shows up the cycle after rdEn
    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrBit;
        end
        if (doRead) begin
            rdBit <= mem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == ptrWidth'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == ptrWidth'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    noWriteWhenFull: assert property (@(posedge clk) disable iff (reset) wrEn |-> !full)
        else $error("bitFifo written while full");

    noReadWhenEmpty: assert property (@(posedge clk) disable iff (reset) rdEn |-> !empty)
        else $error("bitFifo read while empty");

endmodule

//--- hw/dqmPkg.sv
package dqmPkg;

    // Frame sync, sent first in every header
    localparam logic [15:0] dqmSyncWord = 16'hEB90;
    localparam int headerBits = 48;

    // Field widths
    localparam int dqmWidth = 16;
    localparam int sizeWidth = 14;
    localparam int rateWidth = 16;
    localparam int versionWidth = 4;
    localparam int padBits = 12;

    typedef struct packed {
        logic bitEn;
        logic bitVal;
    } payloadIn_t;

    // payloadSize and clksPerBit are stored minus one
    typedef struct packed {
        logic [dqmWidth-1:0]  dqm;
        logic [sizeWidth-1:0] payloadSize;
        logic [rateWidth-1:0] clksPerBit;
    } frameCfg_t;

    typedef struct packed {
        logic bitEn;
        logic bitVal;
    } serialOut_t;

    typedef enum logic {
        writeFlush,
        writeFill
    } writeState_t;

    typedef enum logic [1:0] {
        frameIdle,
        frameWait,
        frameHeader,
        framePayload
    } frameState_t;

endpackage
